// ==== compile.f ====
source/rv_core_pkg.sv
source/inst_mem.sv
source/instr_decoder.sv
source/reg_file.sv
source/alu.sv
source/hazard_unit.sv
source/data_mem.sv
source/rv_core.sv
testbench/tb_rv_core.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f compile.f --top-module tb_rv_core -o tb_rv_core

out=$(./obj_dir/tb_rv_core)
echo "$out"
echo "$out" | grep -qx "TEST PASS"

// ==== testbench/tb_rv_core.sv ====
module tb_rv_core import rv_core_pkg::*; ();

	localparam int imem_words = 1024;
	localparam int dmem_words = 1024;
	localparam int imem_aw    = $clog2(imem_words);
	localparam int dmem_aw    = $clog2(dmem_words);
	localparam int num_tests  = 5;
	// Reset, full imem load, longest program with stalls, read-back, slack
	localparam int test_cycles = 4 + imem_words + 2 * 96 + 8 + 2 * 40 + 64;
	localparam int max_cycles  = num_tests * test_cycles + 200;

	logic               clk;
	logic               rst_n;
	logic               prog_write;
	logic [imem_aw-1:0] prog_addr;
	word_t              prog_in;
	logic [3:0]         con_write;
	logic [dmem_aw-1:0] con_addr;
	word_t              con_in;
	word_t              con_out;

	word_t prog [$];          // Program under test
	int    check_addrs [$];   // Words read back after the run
	word_t mregs [32];        // Reference register file
	word_t mmem [dmem_words]; // Reference data memory
	int    cycle_count  = 0;
	int    tests_passed = 0;
	int    tests_failed = 0;

	rv_core #(.imem_words(imem_words), .dmem_words(dmem_words)) u_rv_core (
		.clk(clk), .rst_n(rst_n),
		.prog_write(prog_write), .prog_addr(prog_addr), .prog_in(prog_in),
		.con_write(con_write), .con_addr(con_addr), .con_in(con_in), .con_out(con_out)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// Watchdog
	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= max_cycles) begin
			$display("timeout: run went past %0d cycles without finishing", max_cycles);
			$display("TEST FAIL");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Instruction encoding
	////////////////////////////////////////////////////////////////////////////

	function automatic word_t lui_inst(int rd, logic [19:0] imm);
		return {imm, 5'(rd), op_lui};
	endfunction

	// sel 0..7 is funct3, 8 is srai
	function automatic word_t imm_inst(int sel, int rd, int rs1);
		logic [2:0]  f3;
		logic [11:0] imm;
		f3 = (sel == 8) ? 3'd5 : 3'(sel);
		imm = 12'($urandom);
		if (f3 == 3'd1 || f3 == 3'd5) imm = {(sel == 8) ? 7'h20 : 7'h00, 5'($urandom)}; // Shamt
		return {imm, 5'(rs1), f3, 5'(rd), op_imm};
	endfunction

	// sel 0..7 is funct3, 8 is sub, 9 is sra
	function automatic word_t reg_inst(int sel, int rd, int rs1, int rs2);
		logic [2:0] f3;
		logic [6:0] f7;
		f3 = (sel == 8) ? 3'd0 : (sel == 9) ? 3'd5 : 3'(sel);
		f7 = (sel >= 8) ? 7'h20 : 7'h00;
		return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), op_reg};
	endfunction

	function automatic word_t load_inst(int rd, int word);
		return {12'(word * 4), 5'd0, 3'b010, 5'(rd), op_load}; // lw rd, off(x0)
	endfunction

	function automatic word_t store_inst(int rs2, int word);
		logic [11:0] off;
		off = 12'(word * 4);
		return {off[11:5], 5'(rs2), 5'd0, 3'b010, off[4:0], op_store};
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Reference model
	////////////////////////////////////////////////////////////////////////////

	function automatic word_t byte_merge(word_t old_w, word_t new_w, logic [3:0] be);
		word_t mask;
		mask = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
		return (old_w & ~mask) | (new_w & mask);
	endfunction

	function automatic word_t alu_ref(logic [2:0] f3, logic alt, word_t a, word_t b);
		word_t r;
		case (f3)
			3'd0: r = alt ? a - b : a + b;
			3'd1: r = a << b[4:0];
			3'd2: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			3'd3: r = (a < b) ? 32'd1 : 32'd0;
			3'd4: r = a ^ b;
			3'd5: begin
				if (alt) r = $signed(a) >>> b[4:0]; // Sign fill
				else r = a >> b[4:0];
			end
			3'd6: r = a | b;
			default: r = a & b;
		endcase
		return r;
	endfunction

	// Executes one instruction in program order
	task automatic model_step(word_t inst);
		word_t a, b, r, imm_i, addr;
		logic  wr;
		a = mregs[inst[19:15]];
		b = mregs[inst[24:20]];
		imm_i = {{20{inst[31]}}, inst[31:20]};
		r = '0;
		wr = 1'b1;
		case (inst[6:0])
			op_lui: r = {inst[31:12], 12'b0};
			op_imm: r = alu_ref(inst[14:12], inst[30] && inst[14:12] == 3'd5, a, imm_i);
			op_reg: r = alu_ref(inst[14:12], inst[30], a, b);
			op_load: begin
				addr = a + imm_i;
				r = mmem[addr[dmem_aw+1:2]];
			end
			op_store: begin
				addr = a + {{20{inst[31]}}, inst[31:25], inst[11:7]};
				mmem[addr[dmem_aw+1:2]] = b;
				wr = 1'b0;
			end
			default: wr = 1'b0; // Unknown opcode is a no-op
		endcase
		if (wr && inst[11:7] != 5'd0) mregs[inst[11:7]] = r;
	endtask

	task automatic begin_test();
		prog.delete();
		check_addrs.delete();
		for (int i = 0; i < 32; i++) mregs[i] = '0; // Registers clear in reset
	endtask

	task automatic emit(word_t inst);
		prog.push_back(inst);
		model_step(inst);
	endtask

	task automatic load_const(int rd, word_t value);
		word_t lo;
		word_t hi;
		lo = {{20{value[11]}}, value[11:0]};
		hi = value - lo; // addi adds lo back sign extended
		emit(lui_inst(rd, hi[31:12]));
		emit({value[11:0], 5'(rd), 3'b000, 5'(rd), op_imm});
	endtask

	// Overcounts on raw fields and only stretches the wait
	function automatic int load_use_pairs();
		int         k;
		logic [4:0] rd;
		k = 0;
		for (int i = 0; i + 1 < prog.size(); i++) begin
			rd = prog[i][11:7];
			if (prog[i][6:0] == op_load && rd != 5'd0 &&
				(prog[i+1][19:15] == rd || prog[i+1][24:20] == rd)) k++;
		end
		return k;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Bus tasks
	////////////////////////////////////////////////////////////////////////////

	task automatic controller_write(int addr, word_t data, logic [3:0] be);
		@(posedge clk);
		con_write <= be;
		con_addr  <= addr[dmem_aw-1:0];
		con_in    <= data;
		mmem[addr] = byte_merge(mmem[addr], data, be);
	endtask

	task automatic controller_idle();
		@(posedge clk);
		con_write <= 4'b0;
	endtask

	task automatic controller_read(int addr, output word_t data);
		@(posedge clk);
		con_write <= 4'b0;
		con_addr  <= addr[dmem_aw-1:0];
		@(posedge clk); // Address taken and word registered
		@(negedge clk);
		data = con_out;
	endtask

	// Core held in reset while the whole imem is written
	task automatic load_program();
		@(posedge clk);
		rst_n <= 1'b0;
		repeat (4) @(posedge clk);
		for (int i = 0; i < imem_words; i++) begin
			@(posedge clk);
			prog_write <= 1'b1;
			prog_addr  <= i[imem_aw-1:0];
			prog_in    <= (i < prog.size()) ? prog[i] : nop_inst; // No-op fill
		end
		@(posedge clk);
		prog_write <= 1'b0;
		rst_n      <= 1'b1;
	endtask

	task automatic run_program();
		int wait_cycles;
		wait_cycles = prog.size() + load_use_pairs() + 8; // Retire bound plus slack
		load_program();
		repeat (wait_cycles) @(posedge clk);
	endtask

	task automatic check_words(string name);
		int    errors;
		word_t got;
		errors = 0;
		foreach (check_addrs[i]) begin
			controller_read(check_addrs[i], got);
			if (got !== mmem[check_addrs[i]]) begin
				$display("error %s: word %0d expected %08h actual %08h",
					name, check_addrs[i], mmem[check_addrs[i]], got);
				errors++;
			end
		end
		if (errors == 0) begin
			tests_passed++;
			$display("%s: passed, %0d words", name, check_addrs.size());
		end else begin
			tests_failed++;
			$display("%s: failed, %0d of %0d words wrong", name, errors, check_addrs.size());
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Tests
	////////////////////////////////////////////////////////////////////////////

	initial begin
		int addr;
		int kind;
		void'($urandom(27324));
		rst_n      <= 1'b0;
		prog_write <= 1'b0;
		prog_addr  <= '0;
		prog_in    <= nop_inst;
		con_write  <= 4'b0;
		con_addr   <= '0;
		con_in     <= '0;
		repeat (4) @(posedge clk);

		// Byte enables on the controller port while the core stays in reset
		begin_test();
		for (int i = 0; i < 16; i++) begin
			addr = i * 64 + int'($urandom % 64); // One word per 64-word block
			check_addrs.push_back(addr);
			controller_write(addr, $urandom, 4'hf);
		end
		for (int i = 0; i < 32; i++) begin
			controller_write(check_addrs[$urandom % 16], $urandom, 4'($urandom));
		end
		controller_idle();
		check_words("controller_port");

		// Immediate ops and LUI
		begin_test();
		for (int r = 0; r < 3; r++) begin
			load_const(1, $urandom);
			for (int s = 0; s < 9; s++) emit(imm_inst(s, 2 + s, 1));
			emit(lui_inst(11, 20'($urandom)));
			for (int j = 0; j < 10; j++) begin
				emit(store_inst(2 + j, 20 + r * 10 + j));
				check_addrs.push_back(20 + r * 10 + j);
			end
		end
		run_program();
		check_words("imm_ops");

		// Dependent chains with rs1 one back and rs2 two back
		begin_test();
		for (int r = 0; r < 2; r++) begin
			load_const(1, $urandom);
			load_const(2, $urandom);
			for (int i = 0; i < 20; i++) emit(reg_inst((i + r * 3) % 10, 3 + i, 2 + i, 1 + i));
			for (int i = 0; i < 20; i++) begin
				emit(store_inst(3 + i, 60 + r * 20 + i));
				check_addrs.push_back(60 + r * 20 + i);
			end
		end
		run_program();
		check_words("reg_chains");

		// Load followed at once by its user
		begin_test();
		for (int i = 0; i < 8; i++) controller_write(100 + i, $urandom, 4'hf);
		controller_idle();
		load_const(7, $urandom);
		for (int i = 0; i < 8; i++) begin
			emit(load_inst(5, 100 + i));
			if (i % 2 == 0) emit(reg_inst(int'($urandom % 10), 6, 5, 7));
			else emit(reg_inst(int'($urandom % 10), 6, 7, 5)); // Load value as rs2
			emit(store_inst(6, 120 + i));
			emit(load_inst(8, 100 + (i + 3) % 8));
			emit(store_inst(8, 130 + i)); // Load straight into store data
			check_addrs.push_back(120 + i);
			check_addrs.push_back(130 + i);
		end
		run_program();
		check_words("load_use");

		// Random mix with loads and stores kept to words 0..15
		begin_test();
		for (int i = 0; i < 16; i++) controller_write(i, $urandom, 4'hf);
		controller_idle();
		for (int i = 0; i < 48; i++) begin
			kind = int'($urandom % 22);
			if (kind == 0) emit(lui_inst(int'($urandom % 32), 20'($urandom)));
			else if (kind < 10)
				emit(imm_inst(kind - 1, int'($urandom % 32), int'($urandom % 32)));
			else if (kind < 20)
				emit(reg_inst(kind - 10, int'($urandom % 32), int'($urandom % 32),
					int'($urandom % 32)));
			else if (kind == 20) emit(load_inst(int'($urandom % 32), int'($urandom % 16)));
			else emit(store_inst(int'($urandom % 32), int'($urandom % 16)));
		end
		for (int j = 1; j < 32; j++) begin
			emit(store_inst(j, 400 + j)); // Register dump
			check_addrs.push_back(400 + j);
		end
		run_program();
		check_words("random_program");

		$display("%0d tests passed, %0d tests failed", tests_passed, tests_failed);
		if (tests_failed == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

// ==== source/rv_core.sv ====
module rv_core import rv_core_pkg::*; #(
	parameter int imem_words = 1024,
	parameter int dmem_words = 1024
) (
	input  logic                          clk,
	input  logic                          rst_n,
	// Program load
	input  logic                          prog_write,
	input  logic [$clog2(imem_words)-1:0] prog_addr,
	input  word_t                         prog_in,
	// Protocol controller port on data memory
	input  logic [3:0]                    con_write,
	input  logic [$clog2(dmem_words)-1:0] con_addr,
	input  word_t                         con_in,
	output word_t                         con_out
);

	localparam int imem_aw = $clog2(imem_words);
	localparam int dmem_aw = $clog2(dmem_words);
	localparam logic [imem_aw+1:0] pc_step = 4;

	logic [imem_aw+1:0] pc;       // Byte address, wraps with memory size
	word_t     id_inst;           // Registered by inst_mem
	reg_addr_t id_rs1, id_rs2, id_rd;
	word_t     id_imm;
	ctrl_t     id_ctrl;
	word_t     id_rd1, id_rd2;    // Register file, already bypassed
	id_exe_t   id_exe;
	exe_mem_t  exe_mem;
	mem_wb_t   mem_wb;
	fwd_sel_e  fwd_a, fwd_b;
	logic      stall;
	word_t     exe_a, exe_b;      // Forwarded operands
	word_t     alu_b;
	word_t     exe_result;
	word_t     mem_rdata;         // Valid in writeback
	word_t     wb_data;

	////////////////////////////////////////////////////////////////////////////
	// Fetch and decode
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!rst_n) pc <= '0;
		else if (!stall) pc <= pc + pc_step; // Straight-line, no jumps
	end

	inst_mem #(.imem_words(imem_words)) u_inst_mem (
		.clk(clk), .rst_n(rst_n), .hold(stall), .fetch_addr(pc[imem_aw+1:2]),
		.prog_write(prog_write), .prog_addr(prog_addr), .prog_in(prog_in), .inst(id_inst)
	);

	instr_decoder u_instr_decoder (
		.inst(id_inst), .rs1(id_rs1), .rs2(id_rs2), .rd(id_rd), .imm(id_imm), .ctrl(id_ctrl)
	);

	reg_file u_reg_file (
		.clk(clk), .rst_n(rst_n), .rs1(id_rs1), .rs2(id_rs2),
		.rd(mem_wb.rd), .wr_en(mem_wb.wr_en), .wr_data(wb_data), .rd1(id_rd1), .rd2(id_rd2)
	);

	hazard_unit u_hazard_unit (
		.exe_rs1(id_exe.rs1), .exe_rs2(id_exe.rs2),
		.mem_rd(exe_mem.rd), .mem_wr_en(exe_mem.ctrl.wr_en), .mem_is_load(exe_mem.ctrl.is_load),
		.wb_rd(mem_wb.rd), .wb_wr_en(mem_wb.wr_en),
		.id_rs1(id_rs1), .id_rs2(id_rs2), .exe_is_load(id_exe.ctrl.is_load), .exe_rd(id_exe.rd),
		.fwd_a(fwd_a), .fwd_b(fwd_b), .stall(stall)
	);

	always_ff @(posedge clk) begin
		if (!rst_n || stall) id_exe.ctrl <= '0; // Bubble on load-use
		else id_exe.ctrl <= id_ctrl;
		id_exe.rs1  <= id_rs1;
		id_exe.rs2  <= id_rs2;
		id_exe.rd   <= id_rd;
		id_exe.op_a <= id_rd1;
		id_exe.op_b <= id_rd2;
		id_exe.imm  <= id_imm;
	end

	////////////////////////////////////////////////////////////////////////////
	// Execute
	////////////////////////////////////////////////////////////////////////////

	function automatic word_t fwd_mux(fwd_sel_e sel, word_t own, word_t mem_v, word_t wb_v);
		case (sel)
			fwd_mem: return mem_v;
			fwd_wb:  return wb_v;
			default: return own;
		endcase
	endfunction

	assign exe_a = fwd_mux(fwd_a, id_exe.op_a, exe_mem.result, wb_data);
	assign exe_b = fwd_mux(fwd_b, id_exe.op_b, exe_mem.result, wb_data); // Store data too
	assign alu_b = id_exe.ctrl.imm_b ? id_exe.imm : exe_b;

	alu u_alu (.a(exe_a), .b(alu_b), .op(id_exe.ctrl.alu_op), .result(exe_result));

	always_ff @(posedge clk) begin
		if (!rst_n) exe_mem.ctrl <= '0;
		else exe_mem.ctrl <= id_exe.ctrl;
		exe_mem.rd         <= id_exe.rd;
		exe_mem.result     <= exe_result;
		exe_mem.store_data <= exe_b;
	end

	////////////////////////////////////////////////////////////////////////////
	// Memory and writeback
	////////////////////////////////////////////////////////////////////////////

	data_mem #(.dmem_words(dmem_words)) u_data_mem (
		.clk(clk),
		.core_write({4{exe_mem.ctrl.is_store}}), // Word stores only
		.core_addr(exe_mem.result[dmem_aw+1:2]), .core_in(exe_mem.store_data),
		.core_out(mem_rdata),
		.con_write(con_write), .con_addr(con_addr), .con_in(con_in), .con_out(con_out)
	);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			mem_wb.wr_en   <= 1'b0;
			mem_wb.is_load <= 1'b0;
		end else begin
			mem_wb.wr_en   <= exe_mem.ctrl.wr_en;
			mem_wb.is_load <= exe_mem.ctrl.is_load;
		end
		mem_wb.rd     <= exe_mem.rd;
		mem_wb.result <= exe_mem.result;
	end

	assign wb_data = mem_wb.is_load ? mem_rdata : mem_wb.result; // Load data arrives here

endmodule

// ==== source/data_mem.sv ====
module data_mem import rv_core_pkg::*; #(
	parameter int dmem_words = 1024
) (
	input  logic                          clk,
	// Core port
	input  logic [3:0]                    core_write,
	input  logic [$clog2(dmem_words)-1:0] core_addr,
	input  word_t                         core_in,
	output word_t                         core_out,
	// Controller port
	input  logic [3:0]                    con_write,
	input  logic [$clog2(dmem_words)-1:0] con_addr,
	input  word_t                         con_in,
	output word_t                         con_out
);

	word_t mem [dmem_words];

	function automatic word_t merge_bytes(word_t old_w, word_t new_w, logic [3:0] be);
		word_t w;
		w = old_w;
		for (int i = 0; i < 4; i++) begin
			if (be[i]) w[8*i +: 8] = new_w[8*i +: 8];
		end
		return w;
	endfunction

	always_ff @(posedge clk) begin
		if (|con_write) mem[con_addr] <= merge_bytes(mem[con_addr], con_in, con_write);
		if (|core_write) mem[core_addr] <= merge_bytes(mem[core_addr], core_in, core_write); // Last, core wins
		core_out <= mem[core_addr]; // Old data on a same-edge write
		con_out  <= mem[con_addr];
	end

endmodule

// ==== source/hazard_unit.sv ====
module hazard_unit import rv_core_pkg::*; (
	// Execute sources
	input  reg_addr_t exe_rs1,
	input  reg_addr_t exe_rs2,
	// Memory stage producer
	input  reg_addr_t mem_rd,
	input  logic      mem_wr_en,
	input  logic      mem_is_load,
	// Writeback producer
	input  reg_addr_t wb_rd,
	input  logic      wb_wr_en,
	// Load-use check
	input  reg_addr_t id_rs1,
	input  reg_addr_t id_rs2,
	input  logic      exe_is_load,
	input  reg_addr_t exe_rd,
	output fwd_sel_e  fwd_a,
	output fwd_sel_e  fwd_b,
	output logic      stall
);

	// wr_en is never set for x0, so a match never hits x0
	function automatic fwd_sel_e pick(reg_addr_t rs);
		if (mem_wr_en && !mem_is_load && mem_rd == rs) return fwd_mem; // Newest first
		if (wb_wr_en && wb_rd == rs) return fwd_wb;
		return fwd_reg;
	endfunction

	assign fwd_a = pick(exe_rs1);
	assign fwd_b = pick(exe_rs2);

	////////////////////////////////////////////////////////////////////////////
	// Load-use
	////////////////////////////////////////////////////////////////////////////

	// Load data only exists from writeback on, so one bubble
	assign stall = exe_is_load && exe_rd != '0 &&
		(exe_rd == id_rs1 || exe_rd == id_rs2);

endmodule

// ==== source/alu.sv ====
module alu import rv_core_pkg::*; (
	input  word_t   a,
	input  word_t   b,
	input  alu_op_e op,
	output word_t   result
);

	logic [4:0] shamt;
	logic       lt_signed;
	logic       lt_unsigned;

	assign shamt       = b[4:0]; // Upper bits of b ignored for shifts
	assign lt_signed   = $signed(a) < $signed(b);
	assign lt_unsigned = a < b;

	always_comb begin
		case (op)
			alu_add:    result = a + b;
			alu_sub:    result = a - b;
			alu_and:    result = a & b;
			alu_or:     result = a | b;
			alu_xor:    result = a ^ b;
			alu_sll:    result = a << shamt;
			alu_srl:    result = a >> shamt;
			alu_sra:    result = $signed(a) >>> shamt;
			alu_slt:    result = {31'b0, lt_signed};
			alu_sltu:   result = {31'b0, lt_unsigned};
			alu_pass_b: result = b;          // LUI
			default:    result = '0;
		endcase
	end

endmodule

// ==== source/reg_file.sv ====
module reg_file import rv_core_pkg::*; (
	input  logic      clk,
	input  logic      rst_n,
	input  reg_addr_t rs1,
	input  reg_addr_t rs2,
	input  reg_addr_t rd,
	input  logic      wr_en,
	input  word_t     wr_data,
	output word_t     rd1,
	output word_t     rd2
);

	word_t regs [1:31]; // x0 has no storage

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 1; i < 32; i++) regs[i] <= '0;
		end else if (wr_en && rd != '0) begin
			regs[rd] <= wr_data;
		end
	end

	// Write-first read, covers the decode/writeback overlap
	function automatic word_t read_port(reg_addr_t rs);
		if (rs == '0) return '0;
		if (wr_en && rd == rs) return wr_data;
		return regs[rs];
	endfunction

	assign rd1 = read_port(rs1);
	assign rd2 = read_port(rs2);

endmodule

// ==== source/instr_decoder.sv ====
module instr_decoder import rv_core_pkg::*; (
	input  word_t     inst,
	output reg_addr_t rs1,
	output reg_addr_t rs2,
	output reg_addr_t rd,
	output word_t     imm,
	output ctrl_t     ctrl
);

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	word_t      imm_i;
	word_t      imm_s;
	word_t      imm_u;

	assign opcode = inst[6:0];
	assign funct3 = inst[14:12];
	assign funct7 = inst[31:25];
	assign rd     = inst[11:7];

	// Immediate formats
	assign imm_i = {{20{inst[31]}}, inst[31:20]};
	assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
	assign imm_u = {inst[31:12], 12'b0};

	// funct3 to ALU op, alt picks sub or sra
	function automatic alu_op_e funct_to_op(logic [2:0] f3, logic alt);
		case (f3)
			3'b000:  return alt ? alu_sub : alu_add;
			3'b001:  return alu_sll;
			3'b010:  return alu_slt;
			3'b011:  return alu_sltu;
			3'b100:  return alu_xor;
			3'b101:  return alt ? alu_sra : alu_srl;
			3'b110:  return alu_or;
			default: return alu_and;
		endcase
	endfunction

	always_comb begin
		ctrl = '0;               // Unknown opcodes fall out as no-ops
		ctrl.alu_op = alu_add;
		imm = imm_i;
		rs1 = inst[19:15];
		rs2 = inst[24:20];
		case (opcode)
			op_lui: begin
				ctrl.alu_op = alu_pass_b;
				ctrl.imm_b = 1'b1;
				ctrl.wr_en = 1'b1;
				imm = imm_u;
				rs1 = '0;            // Source fields are immediate bits
				rs2 = '0;
			end
			op_imm: begin
				// Bit 30 only matters for srai, addi keeps its sign bits
				ctrl.alu_op = funct_to_op(funct3, funct7[5] && funct3 == 3'b101);
				ctrl.imm_b = 1'b1;
				ctrl.wr_en = 1'b1;
				rs2 = '0;
			end
			op_reg: begin
				ctrl.alu_op = funct_to_op(funct3, funct7[5]);
				ctrl.wr_en = 1'b1;
			end
			op_load: begin
				ctrl.imm_b = 1'b1;   // Address is rs1 + imm
				ctrl.is_load = 1'b1;
				ctrl.wr_en = 1'b1;
				rs2 = '0;
			end
			op_store: begin
				ctrl.imm_b = 1'b1;
				ctrl.is_store = 1'b1;
				imm = imm_s;         // rs2 stays, it is the store data
			end
			default: begin
				rs1 = '0;            // Keeps a no-op out of the hazard checks
				rs2 = '0;
			end
		endcase
		if (rd == '0) ctrl.wr_en = 1'b0; // x0 is never written
	end

endmodule

// ==== source/inst_mem.sv ====
module inst_mem import rv_core_pkg::*; #(
	parameter int imem_words = 1024
) (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          hold,       // Load-use stall
	input  logic [$clog2(imem_words)-1:0] fetch_addr, // Word index
	input  logic                          prog_write,
	input  logic [$clog2(imem_words)-1:0] prog_addr,
	input  word_t                         prog_in,
	output word_t                         inst
);

	word_t mem [imem_words];

	// Program load port
	always_ff @(posedge clk) begin
		if (prog_write) mem[prog_addr] <= prog_in;
	end

	// Registered read, this is the IF/ID register
	always_ff @(posedge clk) begin
		if (!rst_n) inst <= nop_inst; // Decode sees no-ops in reset
		else if (!hold) inst <= mem[fetch_addr];
	end

endmodule

// ==== source/rv_core_pkg.sv ====
package rv_core_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Basic widths
	////////////////////////////////////////////////////////////////////////////

	typedef logic [31:0] word_t;     // Data or instruction word
	typedef logic [4:0]  reg_addr_t; // Register index

	// ALU operations, pass_b carries the LUI immediate
	typedef enum logic [3:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_xor,
		alu_sll,
		alu_srl,
		alu_sra,
		alu_slt,
		alu_sltu,
		alu_pass_b
	} alu_op_e;

	// Source of an execute operand
	typedef enum logic [1:0] {
		fwd_reg, // Value latched in id_exe
		fwd_mem, // ALU result in memory stage
		fwd_wb   // Writeback data
	} fwd_sel_e;

	// Opcodes kept in this core
	localparam logic [6:0] op_lui   = 7'h37;
	localparam logic [6:0] op_imm   = 7'h13;
	localparam logic [6:0] op_reg   = 7'h33;
	localparam logic [6:0] op_load  = 7'h03;
	localparam logic [6:0] op_store = 7'h23;

	localparam word_t nop_inst = 32'h0000_0013; // addi x0, x0, 0

	////////////////////////////////////////////////////////////////////////////
	// Pipeline registers
	////////////////////////////////////////////////////////////////////////////

	typedef struct packed {
		alu_op_e alu_op;
		logic    imm_b;    // Immediate replaces operand B
		logic    is_load;
		logic    is_store;
		logic    wr_en;    // Register write, never set for x0
	} ctrl_t;

	typedef struct packed {
		ctrl_t     ctrl;
		reg_addr_t rs1;
		reg_addr_t rs2;
		reg_addr_t rd;
		word_t     op_a;
		word_t     op_b; // Also the store data
		word_t     imm;
	} id_exe_t;

	typedef struct packed {
		ctrl_t     ctrl;
		reg_addr_t rd;
		word_t     result;     // ALU result or load/store address
		word_t     store_data;
	} exe_mem_t;

	typedef struct packed {
		logic      wr_en;
		logic      is_load; // Take data_mem output instead of result
		reg_addr_t rd;
		word_t     result;
	} mem_wb_t;

endpackage
